/* files.f */
rtl/sprite_pkg.sv
rtl/display_timing.sv
rtl/sprite_registers.sv
rtl/sprite_line_engine.sv
rtl/sprite_compositor.sv
rtl/sprite_display_top.sv
verif/sprite_display_tb.sv

/* rtl/display_timing.sv */
// raster counters for 640x480, syncs active low and not registered here
// line and frame strobes are decoded straight from the counters
`timescale 1ns/100ps

module display_timing (
    input  logic                clk_pix,
    input  logic                rst_n,
    output sprite_pkg::coord_t  sx,     // current column
    output sprite_pkg::coord_t  sy,     // current line
    output logic                hsync,
    output logic                vsync,
    output logic                de,     // visible area
    output logic                line,   // one cycle at sx == H_RES
    output logic                frame   // one cycle at the very last pixel
);

    logic h_last;  // end of line
    logic v_last;  // last line of frame

    assign h_last = (sx == sprite_pkg::coord_t'(sprite_pkg::H_TOTAL - 1));
    assign v_last = (sy == sprite_pkg::coord_t'(sprite_pkg::V_TOTAL - 1));

    // counters, sx runs every cycle, sy steps at end of line
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else begin
            if (h_last) begin
                sx <= '0;
                sy <= v_last ? '0 : sy + 1'b1;
            end else begin
                sx <= sx + 1'b1;
            end
        end
    end

    // sync windows start after the front porch
    always_comb begin
        hsync = !(sx >= sprite_pkg::H_RES + sprite_pkg::H_FP &&
                  sx <  sprite_pkg::H_RES + sprite_pkg::H_FP + sprite_pkg::H_SYNC);
        vsync = !(sy >= sprite_pkg::V_RES + sprite_pkg::V_FP &&
                  sy <  sprite_pkg::V_RES + sprite_pkg::V_FP + sprite_pkg::V_SYNC);
        de    = (sx < sprite_pkg::H_RES) && (sy < sprite_pkg::V_RES);
    end

    assign line  = (sx == sprite_pkg::coord_t'(sprite_pkg::H_RES));  // every line, blank too
    assign frame = h_last && v_last;

    // column counter must wrap before leaving the line
    a_sx_range: assert property (@(posedge clk_pix) disable iff (!rst_n)
        sx < sprite_pkg::H_TOTAL && sy < sprite_pkg::V_TOTAL)
        else $error("raster counter out of range");

endmodule

/* rtl/sprite_compositor.sv */
// lowest numbered opaque sprite wins over the background
// de and syncs must arrive already aligned with the engine pix bits
`timescale 1ns/100ps

module sprite_compositor (
    input  logic                      clk_pix,
    input  logic                      rst_n,
    input  logic [sprite_pkg::N_SPR-1:0] pix,
    input  sprite_pkg::colour_t       spr_colour [sprite_pkg::N_SPR],
    input  logic                      de_d,
    input  logic                      hsync_d,
    input  logic                      vsync_d,
    output sprite_pkg::channel_t      vga_r,
    output sprite_pkg::channel_t      vga_g,
    output sprite_pkg::channel_t      vga_b,
    output logic                      vga_hsync,
    output logic                      vga_vsync
);

    sprite_pkg::colour_t mix;  // colour before the output register

    always_comb begin
        mix = sprite_pkg::BG_COLOUR;
        // walk down so sprite 0 is written last and wins
        for (int i = sprite_pkg::N_SPR - 1; i >= 0; i--) begin
            if (pix[i])
                mix = spr_colour[i];
        end
        if (!de_d)
            mix = '0;  // black in blanking
    end

    // output stage, syncs idle high in reset
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
        end else begin
            vga_r     <= mix[11:8];
            vga_g     <= mix[7:4];
            vga_b     <= mix[3:0];
            vga_hsync <= hsync_d;
            vga_vsync <= vsync_d;
        end
    end

endmodule

/* rtl/sprite_display_top.sv */
// four hardware sprites over a flat background, pixel clock domain only
// pixel at (x, y) shows on rgb two cycles after the counters reach it
`timescale 1ns/100ps

module sprite_display_top (
    input  logic                   clk_pix,
    input  logic                   rst_n,
    input  logic                   reg_we,
    input  sprite_pkg::reg_addr_t  reg_addr,
    input  sprite_pkg::reg_data_t  reg_wdata,
    output logic                   vga_hsync,
    output logic                   vga_vsync,
    output sprite_pkg::channel_t   vga_r,
    output sprite_pkg::channel_t   vga_g,
    output sprite_pkg::channel_t   vga_b
);

    sprite_pkg::coord_t   sx, sy;
    logic                 hsync, vsync, de, line, frame;
    logic                 de_d, hsync_d, vsync_d;  // match engine latency

    sprite_pkg::coord_t   spr_x      [sprite_pkg::N_SPR];
    sprite_pkg::coord_t   spr_y      [sprite_pkg::N_SPR];
    sprite_pkg::colour_t  spr_colour [sprite_pkg::N_SPR];
    sprite_pkg::glyph_t   spr_glyph  [sprite_pkg::N_SPR];
    logic [sprite_pkg::N_SPR-1:0] pix;

    display_timing u_timing (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .line    (line),
        .frame   (frame)
    );

    sprite_registers u_regs (
        .clk_pix    (clk_pix),
        .rst_n      (rst_n),
        .frame      (frame),
        .reg_we     (reg_we),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .spr_x      (spr_x),
        .spr_y      (spr_y),
        .spr_colour (spr_colour),
        .spr_glyph  (spr_glyph)
    );

    // one engine per sprite
    for (genvar i = 0; i < sprite_pkg::N_SPR; i++) begin : g_engine
        sprite_line_engine u_engine (
            .clk_pix   (clk_pix),
            .rst_n     (rst_n),
            .line      (line),
            .sx        (sx),
            .sy        (sy),
            .spr_x     (spr_x[i]),
            .spr_y     (spr_y[i]),
            .spr_glyph (spr_glyph[i]),
            .pix       (pix[i])
        );
    end

    // one stage delay, same as the engine pix register
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            de_d    <= 1'b0;
            hsync_d <= 1'b1;
            vsync_d <= 1'b1;
        end else begin
            de_d    <= de;
            hsync_d <= hsync;
            vsync_d <= vsync;
        end
    end

    sprite_compositor u_comp (
        .clk_pix    (clk_pix),
        .rst_n      (rst_n),
        .pix        (pix),
        .spr_colour (spr_colour),
        .de_d       (de_d),
        .hsync_d    (hsync_d),
        .vsync_d    (vsync_d),
        .vga_r      (vga_r),
        .vga_g      (vga_g),
        .vga_b      (vga_b),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync)
    );

endmodule

/* rtl/sprite_line_engine.sv */
// one 8x8 sprite, row fetched at the line strobe for the next line
// drawing stops at the last visible column, no wrap past the line end
`timescale 1ns/100ps

module sprite_line_engine (
    input  logic                 clk_pix,
    input  logic                 rst_n,
    input  logic                 line,       // start of horizontal blank
    input  sprite_pkg::coord_t   sx,
    input  sprite_pkg::coord_t   sy,
    input  sprite_pkg::coord_t   spr_x,      // live position
    input  sprite_pkg::coord_t   spr_y,
    input  sprite_pkg::glyph_t   spr_glyph,
    output logic                 pix         // registered, one cycle after sx
);

    typedef enum logic [1:0] {
        IDLE,   // nothing on this line
        ARMED,  // row loaded, waiting for spr_x
        DRAW,
        DONE    // row finished, wait for next line
    } state_t;

    state_t              state;
    sprite_pkg::row_t    row;         // row for the current line
    sprite_pkg::row_t    row_new;     // candidate at the strobe
    sprite_pkg::coord_t  y_next;      // line being prepared
    sprite_pkg::coord_t  dy;          // row number within glyph
    sprite_pkg::coord_t  offset;      // column within glyph
    logic [2:0]          bit_sel;
    logic [63:0]         glyph_bits;  // 8 rows, top row in the high byte
    logic                last_col;    // last visible column

    // next line with wrap at the end of the frame
    assign y_next = (sy == sprite_pkg::coord_t'(sprite_pkg::V_TOTAL - 1)) ? '0 : sy + 1'b1;
    assign dy     = y_next - spr_y;   // huge when above the sprite
    assign offset = sx - spr_x;
    assign bit_sel  = 3'd7 - offset[2:0];  // bit 7 drawn first
    assign last_col = (sx == sprite_pkg::coord_t'(sprite_pkg::H_RES - 1));

    // glyph set, rows listed top to bottom in hex
    // 0 solid      FF FF FF FF FF FF FF FF
    // 1 outline    FF 81 81 81 81 81 81 FF
    // 2 letter F   7E 40 40 7C 40 40 40 00
    // 3 checker    AA 55 AA 55 AA 55 AA 55
    // 4 diagonal   80 40 20 10 08 04 02 01
    // 5 cross      18 18 18 FF FF 18 18 18
    // 6 h bars     FF 00 FF 00 FF 00 FF 00
    // 7 v bars     CC CC CC CC CC CC CC CC
    always_comb begin
        case (spr_glyph)
            3'd0:    glyph_bits = 64'hFFFF_FFFF_FFFF_FFFF;
            3'd1:    glyph_bits = 64'hFF81_8181_8181_81FF;
            3'd2:    glyph_bits = 64'h7E40_407C_4040_4000;
            3'd3:    glyph_bits = 64'hAA55_AA55_AA55_AA55;
            3'd4:    glyph_bits = 64'h8040_2010_0804_0201;
            3'd5:    glyph_bits = 64'h1818_18FF_FF18_1818;
            3'd6:    glyph_bits = 64'hFF00_FF00_FF00_FF00;
            default: glyph_bits = 64'hCCCC_CCCC_CCCC_CCCC;
        endcase
        row_new = glyph_bits[63 - 8*dy[2:0] -: 8];
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state <= IDLE;
            pix   <= 1'b0;
        end else begin
            pix <= 1'b0;  // default transparent
            if (line) begin
                if (dy < sprite_pkg::SPR_SIZE) begin
                    row   <= row_new;
                    state <= ARMED;
                end else begin
                    state <= IDLE;
                end
            end else begin
                case (state)
                    ARMED: begin
                        // only start inside the visible area
                        if (sx == spr_x && sx < sprite_pkg::H_RES) begin
                            pix   <= row[sprite_pkg::SPR_SIZE-1];
                            state <= last_col ? DONE : DRAW;
                        end
                    end
                    DRAW: begin
                        pix <= row[bit_sel];
                        if (offset == sprite_pkg::SPR_SIZE - 1 || last_col)
                            state <= DONE;
                    end
                    default: ;  // IDLE and DONE hold
                endcase
            end
        end
    end

    // a row must be finished before the next one loads
    a_no_draw_on_line: assert property (@(posedge clk_pix) disable iff (!rst_n)
        line |-> state != DRAW)
        else $error("sprite still drawing at line strobe");

endmodule

/* rtl/sprite_pkg.sv */
// shared constants and types for the sprite display, 640x480 at 60 Hz only
// timing values assume a 25.175 MHz pixel clock supplied from outside
package sprite_pkg;

    // horizontal timing in pixels
    localparam int H_RES   = 640;
    localparam int H_FP    = 16;
    localparam int H_SYNC  = 96;
    localparam int H_BP    = 48;
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 800

    // vertical timing in lines
    localparam int V_RES   = 480;
    localparam int V_FP    = 10;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 33;
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 525

    // sprites
    localparam int N_SPR    = 4;  // engines, also sets the index bits in the address
    localparam int SPR_SIZE = 8;  // square glyphs
    localparam int N_GLYPH  = 8;  // inline patterns per engine

    // plain vectors with a meaning
    typedef logic [15:0]                  coord_t;     // unsigned screen position
    typedef logic [$clog2(N_GLYPH)-1:0]   glyph_t;     // pattern select
    typedef logic [11:0]                  colour_t;    // rgb444, red on top
    typedef logic [3:0]                   channel_t;   // one colour channel
    typedef logic [3:0]                   reg_addr_t;  // {sprite, field}
    typedef logic [15:0]                  reg_data_t;
    typedef logic [SPR_SIZE-1:0]          row_t;       // bit 7 is leftmost

    // dark blue backdrop
    localparam colour_t BG_COLOUR = 12'h137;

    // field codes, low two address bits
    localparam logic [1:0] REG_X      = 2'd0;
    localparam logic [1:0] REG_Y      = 2'd1;
    localparam logic [1:0] REG_GLYPH  = 2'd2;
    localparam logic [1:0] REG_COLOUR = 2'd3;

endpackage

/* rtl/sprite_registers.sv */
// sprite settings written into shadow copies, moved to live once per frame
// no readback and no back-pressure, extra data bits are dropped per field
`timescale 1ns/100ps

module sprite_registers (
    input  logic                   clk_pix,
    input  logic                   rst_n,
    input  logic                   frame,      // commit strobe
    input  logic                   reg_we,     // single cycle write
    input  sprite_pkg::reg_addr_t  reg_addr,
    input  sprite_pkg::reg_data_t  reg_wdata,
    output sprite_pkg::coord_t     spr_x      [sprite_pkg::N_SPR],
    output sprite_pkg::coord_t     spr_y      [sprite_pkg::N_SPR],
    output sprite_pkg::colour_t    spr_colour [sprite_pkg::N_SPR],
    output sprite_pkg::glyph_t     spr_glyph  [sprite_pkg::N_SPR]
);

    // shadow set, written at any time
    sprite_pkg::coord_t   sh_x      [sprite_pkg::N_SPR];
    sprite_pkg::coord_t   sh_y      [sprite_pkg::N_SPR];
    sprite_pkg::colour_t  sh_colour [sprite_pkg::N_SPR];
    sprite_pkg::glyph_t   sh_glyph  [sprite_pkg::N_SPR];

    logic [1:0] wr_idx;    // which sprite
    logic [1:0] wr_field;  // which setting

    assign wr_idx   = reg_addr[3:2];
    assign wr_field = reg_addr[1:0];

    // write decode
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            for (int i = 0; i < sprite_pkg::N_SPR; i++) begin
                sh_x[i]      <= '0;
                sh_y[i]      <= '0;
                sh_colour[i] <= '0;
                sh_glyph[i]  <= '0;
            end
        end else if (reg_we) begin
            case (wr_field)
                sprite_pkg::REG_X:      sh_x[wr_idx]      <= reg_wdata;
                sprite_pkg::REG_Y:      sh_y[wr_idx]      <= reg_wdata;
                sprite_pkg::REG_GLYPH:  sh_glyph[wr_idx]  <= sprite_pkg::glyph_t'(reg_wdata);
                sprite_pkg::REG_COLOUR: sh_colour[wr_idx] <= sprite_pkg::colour_t'(reg_wdata);
                default: ;
            endcase
        end
    end

    // frame commit, a write on the same edge stays in shadow until next frame
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            for (int i = 0; i < sprite_pkg::N_SPR; i++) begin
                spr_x[i]      <= '0;
                spr_y[i]      <= '0;
                spr_colour[i] <= '0;
                spr_glyph[i]  <= '0;
            end
        end else if (frame) begin
            for (int i = 0; i < sprite_pkg::N_SPR; i++) begin
                spr_x[i]      <= sh_x[i];
                spr_y[i]      <= sh_y[i];
                spr_colour[i] <= sh_colour[i];
                spr_glyph[i]  <= sh_glyph[i];
            end
        end
    end

    // sender must present a clean address with every strobe
    a_addr_known: assert property (@(posedge clk_pix) disable iff (!rst_n)
        reg_we |-> !$isunknown(reg_addr))
        else $error("register write with unknown address");

endmodule

/* verif/sprite_display_tb.sv */
// reads register writes, frame waits and pixel checks from the vector file
// expects the 2 cycle counter to rgb latency, position tracked from reset release
`timescale 1ns/100ps

module sprite_display_tb;

    localparam TEST_FILE = "verif/sprite_display_tests.txt";
    localparam int FRAME_CYCLES = sprite_pkg::H_TOTAL * sprite_pkg::V_TOTAL;

    logic                   clk_pix;
    logic                   rst_n;
    logic                   reg_we;
    sprite_pkg::reg_addr_t  reg_addr;
    sprite_pkg::reg_data_t  reg_wdata;
    logic                   vga_hsync;
    logic                   vga_vsync;
    sprite_pkg::channel_t   vga_r;
    sprite_pkg::channel_t   vga_g;
    sprite_pkg::channel_t   vga_b;

    sprite_pkg::coord_t     tb_sx;     // own raster model
    sprite_pkg::coord_t     tb_sy;
    int                     cycles;    // since reset release
    int                     limit;     // timeout in cycles
    int                     n_checks;  // pixel records done

    sprite_display_top uut (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    initial begin
        clk_pix = 1'b0;
        forever #10 clk_pix = ~clk_pix;  // 50 MHz sim clock, rate does not matter
    end

    // one clock, then advance the model and watch the limit
    task automatic step();
        @(posedge clk_pix);
        #2;
        cycles++;
        if (tb_sx == sprite_pkg::coord_t'(sprite_pkg::H_TOTAL - 1)) begin
            tb_sx = '0;
            tb_sy = (tb_sy == sprite_pkg::coord_t'(sprite_pkg::V_TOTAL - 1)) ? '0 : tb_sy + 1'b1;
        end else begin
            tb_sx = tb_sx + 1'b1;
        end
        if (cycles > limit) begin
            $display("timeout: test file not finished after %0d cycles", cycles);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    endtask

    task automatic check_channel(input logic [8*24-1:0] name, input string chan,
                                 input sprite_pkg::channel_t exp,
                                 input sprite_pkg::channel_t act);
        if (act !== exp) begin
            $display("FAIL %0s %0s: expected %h actual %h", name, chan, exp, act);
            $display("Simulation failed");
            $fatal(1, "colour mismatch");
        end
    endtask

    task automatic check_bit(input logic [8*24-1:0] name, input string what,
                             input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %0s %0s: expected %b actual %b", name, what, exp, act);
            $display("Simulation failed");
            $fatal(1, "sync mismatch");
        end
    endtask

    // strobe lands on the next edge
    task automatic apply_write(input sprite_pkg::reg_addr_t addr,
                               input sprite_pkg::reg_data_t data);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        step();
        reg_we    = 1'b0;
    endtask

    // stops at (0, 0), just after the commit edge
    task automatic wait_frame();
        step();
        while (!(tb_sx == 0 && tb_sy == 0))
            step();
    endtask

    // pixel (x, y) is on rgb once the model is 2 cycles further on
    task automatic check_pixel(input logic [8*24-1:0] name, input int x, input int y,
                               input sprite_pkg::colour_t exp_rgb,
                               input logic exp_hs, input logic exp_vs);
        int pos;
        int tx;
        int ty;
        pos = (y * sprite_pkg::H_TOTAL + x + 2) % FRAME_CYCLES;  // wraps past frame end
        tx  = pos % sprite_pkg::H_TOTAL;
        ty  = pos / sprite_pkg::H_TOTAL;
        while (!(tb_sx == tx && tb_sy == ty))
            step();
        check_channel(name, "red", exp_rgb[11:8], vga_r);
        check_channel(name, "green", exp_rgb[7:4], vga_g);
        check_channel(name, "blue", exp_rgb[3:0], vga_b);
        check_bit(name, "hsync", exp_hs, vga_hsync);
        check_bit(name, "vsync", exp_vs, vga_vsync);
        n_checks++;
    endtask

    // first pass, only F records matter for the limit
    task automatic count_frame_records(output int n);
        int                fd;
        int                code;
        logic [8*24-1:0]   tok;
        logic [8*128-1:0]  rest;
        n  = 0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the test vector file");
            $display("Simulation failed");
            $fatal(1, "missing vectors");
        end
        code = $fscanf(fd, " %s", tok);
        while (code == 1) begin
            if (tok == "F")
                n++;
            code = $fgets(rest, fd);  // drop rest of record
            code = $fscanf(fd, " %s", tok);
        end
        $fclose(fd);
    endtask

    initial begin
        int                     fd;
        int                     code;
        int                     n_frames;
        int                     x;
        int                     y;
        logic                   done;
        logic [8*24-1:0]        tok;
        logic [8*24-1:0]        name;
        logic [8*128-1:0]       rest;
        sprite_pkg::reg_addr_t  addr;
        sprite_pkg::reg_data_t  data;
        sprite_pkg::colour_t    exp_rgb;
        logic                   exp_hs;
        logic                   exp_vs;

        rst_n     = 1'b0;
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        tb_sx     = '0;
        tb_sy     = '0;
        cycles    = 0;
        n_checks  = 0;
        count_frame_records(n_frames);
        limit = n_frames * 3 * FRAME_CYCLES + 1000;

        repeat (16) @(posedge clk_pix);
        #2;
        check_channel("reset_hold", "red", 4'h0, vga_r);  // outputs parked in reset
        check_channel("reset_hold", "green", 4'h0, vga_g);
        check_channel("reset_hold", "blue", 4'h0, vga_b);
        check_bit("reset_hold", "hsync", 1'b1, vga_hsync);
        check_bit("reset_hold", "vsync", 1'b1, vga_vsync);
        rst_n = 1'b1;  // counters at (0, 0) from here

        fd = $fopen(TEST_FILE, "r");
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %s", tok);
            if (code != 1) begin
                done = 1'b1;
            end else if (tok == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "W") begin
                code = $fscanf(fd, " %h %h", addr, data);
                apply_write(addr, data);
            end else if (tok == "F") begin
                wait_frame();
            end else if (tok == "P") begin
                code = $fscanf(fd, " %s %d %d %h %b %b", name, x, y, exp_rgb, exp_hs, exp_vs);
                check_pixel(name, x, y, exp_rgb, exp_hs, exp_vs);
            end else begin
                $display("unknown record kind %0s in the test file", tok);
                $display("Simulation failed");
                $fatal(1, "bad vector file");
            end
        end
        $fclose(fd);

        if (n_checks == 0) begin
            $display("no pixel records were checked");
            $display("Simulation failed");
            $fatal(1, "empty vector file");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* verif/sprite_display_tests.txt */
# W addr data in hex | F wait for next frame | P name x y rgb hsync vsync
# rgb is 12 bit hex with red first, background 137, syncs active low
W 0 0064
W 1 0064
W 3 0F00
W 4 00C8
W 5 0096
W 7 00F0
W 8 012C
W 9 00C8
W A 0002
W B 0FF0
W C 00CC
W D 0098
W F 000F
P spr0_pending 100 100 137 1 1
P bg_mid 320 240 137 1 1
P hblank_black 700 240 000 0 1
P hs_before 655 300 000 1 1
P hs_first 656 300 000 0 1
P hs_last 751 300 000 0 1
P hs_after 752 300 000 1 1
P vs_before 100 489 000 1 1
P vs_first 100 490 000 1 0
P vs_last 100 491 000 1 0
P vs_after 100 492 000 1 1
P vblank_black 320 500 000 1 1
F
P spr0_above 100 99 137 1 1
P spr0_left_out 99 100 137 1 1
P spr0_top_left 100 100 F00 1 1
P spr0_right_out 108 100 137 1 1
P spr0_bot_right 107 107 F00 1 1
P spr0_below 100 108 137 1 1
P prio_overlap 205 153 0F0 1 1
P spr3_alone 209 153 00F 1 1
P glyph_f_r0c0 300 200 137 1 1
P glyph_f_r0c1 301 200 FF0 1 1
P glyph_f_r3c5 305 203 FF0 1 1
P glyph_f_r3c6 306 203 137 1 1
W 0 0190
W 0 027C
W A 0003
F
P spr0_moved 100 100 137 1 1
P first_write_gone 400 100 137 1 1
P edge_first 636 100 F00 1 1
P edge_last 639 100 F00 1 1
P edge_cut 640 100 000 1 1
P checker_r0c0 300 200 FF0 1 1
P checker_r0c1 301 200 137 1 1
P checker_r1c0 300 201 137 1 1
